//--- msp_frontend.f
+incdir+logic
logic/isa_pkg.sv
logic/frontend_pkg.sv
logic/addr_mode_decoder.sv
logic/opcode_decoder.sv
logic/ext_word_capture.sv
logic/fetch_sequencer.sv
logic/msp_frontend_top.sv
test/msp_frontend_chk.sv
test/tb_msp_frontend.sv

//--- Bender.yml
package:
  name: msp_frontend

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/isa_pkg.sv
      - logic/frontend_pkg.sv
      - logic/addr_mode_decoder.sv
      - logic/opcode_decoder.sv
      - logic/ext_word_capture.sv
      - logic/fetch_sequencer.sv
      - logic/msp_frontend_top.sv
  - target: test
    files:
      - test/msp_frontend_chk.sv
      - test/tb_msp_frontend.sv

//--- test/tb_msp_frontend.sv
/* Testbench for the fetch and decode frontend
   Directed instructions, then a random word stream, checked by the bound assertions */
module tb_msp_frontend;
  timeunit 1ns;
  timeprecision 100ps;

  // Directed part about 100 cycles, random part at most 2 cycles per word
  localparam int MAX_CYCLES = 100 + 200 * 2 + 100;

  logic                    mclk_decode;
  logic                    puc_rst;
  isa_pkg::word_t          i_ir;
  logic                    i_ir_vld;
  frontend_pkg::dec_inst_t o_inst;
  isa_pkg::word_t          o_sext;
  isa_pkg::word_t          o_dext;
  logic                    o_inst_vld;

  int seed;
  int cycles;
  int err_cnt;
  int done_cnt;

  msp_frontend_top uut (
    .mclk_decode (mclk_decode),
    .puc_rst     (puc_rst),
    .i_ir        (i_ir),
    .i_ir_vld    (i_ir_vld),
    .o_inst      (o_inst),
    .o_sext      (o_sext),
    .o_dext      (o_dext),
    .o_inst_vld  (o_inst_vld)
  );

  // 4 ns clock
  initial begin
    mclk_decode = 1'b0;
    forever #2 mclk_decode = ~mclk_decode;
  end

  //////////////////////////////////////////////////////////////////////
  // Bus driving
  //////////////////////////////////////////////////////////////////////

  // Idle cycles first, then one valid word
  task automatic put_word(input isa_pkg::word_t w, input int gap);
    repeat (gap) @(posedge mclk_decode);
    i_ir     <= w;
    i_ir_vld <= 1'b1;
    @(posedge mclk_decode);
    i_ir_vld <= 1'b0;
  endtask

  // Done pulse read at the falling edge
  task automatic wait_done;
    int n;
    n = 0;
    @(negedge mclk_decode);
    while (!o_inst_vld && n < 8) begin
      @(negedge mclk_decode);
      n++;
    end
    if (o_inst_vld) begin
      done_cnt++;
    end else begin
      err_cnt++;
      $display("No instruction done pulse within 8 cycles of the last word");
    end
    @(posedge mclk_decode);
  endtask

  task automatic send_inst(input isa_pkg::word_t w0, input isa_pkg::word_t w1,
                           input isa_pkg::word_t w2, input int n, input int gap);
    put_word(w0, 0);
    if (n > 1) put_word(w1, gap);
    if (n > 2) put_word(w2, gap);
    wait_done();
  endtask

  // Watchdog
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge mclk_decode);
      cycles++;
    end
    $display("Run stopped after %0d cycles before the test sequence ended", cycles);
    $display("Simulation FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    isa_pkg::word_t w;
    int             gap;
    int             total;
    seed     = 32'h8d521503;
    err_cnt  = 0;
    done_cnt = 0;
    puc_rst  = 1'b1;
    i_ir     <= '0;
    i_ir_vld <= 1'b0;
    repeat (3) @(posedge mclk_decode);
    puc_rst <= 1'b0;
    repeat (2) @(posedge mclk_decode);

    // Register direct, MOV and ADD
    send_inst(16'h4506, 16'h0000, 16'h0000, 1, 0);
    send_inst(16'h5407, 16'h0000, 16'h0000, 1, 0);
    send_inst(16'hb90a, 16'h0000, 16'h0000, 1, 0);
    // Constants from R3 and R2
    send_inst(16'h4338, 16'h0000, 16'h0000, 1, 0);
    send_inst(16'h4318, 16'h0000, 16'h0000, 1, 0);
    send_inst(16'h4238, 16'h0000, 16'h0000, 1, 0);
    send_inst(16'h4229, 16'h0000, 16'h0000, 1, 0);
    // Jumps backward and forward
    send_inst(16'h3ffd, 16'h0000, 16'h0000, 1, 0);
    send_inst(16'h2005, 16'h0000, 16'h0000, 1, 0);
    // Indexed source, absolute destination, with gaps
    send_inst(16'h4592, 16'h0004, 16'h0200, 3, 0);
    send_inst(16'h4592, 16'h1111, 16'h2222, 3, 3);
    // Symbolic destination, source, both
    send_inst(16'h4580, 16'h1234, 16'h0000, 2, 2);
    send_inst(16'h4016, 16'h0400, 16'h0000, 2, 1);
    send_inst(16'h4090, 16'h0010, 16'h0020, 3, 1);
    // PUSH, CALL and PUSH immediate
    send_inst(16'h1209, 16'h0000, 16'h0000, 1, 0);
    send_inst(16'h128a, 16'h0000, 16'h0000, 1, 0);
    send_inst(16'h1230, 16'habcd, 16'h0000, 2, 1);

    // Random words, each one first or extension as the stream falls
    for (int i = 0; i < 200; i++) begin
      w   = $random(seed);
      gap = $random(seed) & 1;
      put_word(w, gap);
    end
    repeat (4) @(posedge mclk_decode);

    total = err_cnt + uut.u_chk.fail_cnt;
    $display("Summary: %0d directed done pulses, %0d assertion failures, %0d testbench errors",
             done_cnt, uut.u_chk.fail_cnt, err_cnt);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- test/msp_frontend_chk.sv
/* Bound checker for the frontend top level, holding a reference model of the ISA rules
   Bound to the top level with a failure count read by the testbench */
module msp_frontend_chk (
  input logic                    mclk_decode,
  input logic                    puc_rst,
  input isa_pkg::word_t          i_ir,
  input logic                    i_ir_vld,
  input frontend_pkg::dec_inst_t i_inst,
  input isa_pkg::word_t          i_sext,
  input isa_pkg::word_t          i_dext,
  input logic                    i_inst_vld
);
  timeunit 1ns;
  timeprecision 100ps;

  // ALU controls per two-operand opcode from MOV up to AND
  localparam logic [11:0] TO_ALU [0:11] = '{
    12'h000, 12'h208, 12'h20c, 12'h20d, 12'h20b, 12'ha0b,
    12'h284, 12'hb10, 12'h011, 12'h020, 12'h240, 12'h310
  };
  // Single-operand ALU controls from RRC up to RETI and the unused opcode 7
  localparam logic [11:0] SO_ALU [0:7] = '{
    12'h600, 12'h000, 12'h600, 12'h300, 12'h000, 12'h000, 12'h008, 12'h000
  };

  int                fail_cnt = 0;
  logic              seen_first;
  logic              exp_vld;
  logic [1:0]        pend;
  isa_pkg::word_t    fw;
  isa_pkg::word_t    exp_sext;
  isa_pkg::word_t    exp_dext;
  isa_pkg::as_1hot_t as_in;
  isa_pkg::as_1hot_t as_fw;
  isa_pkg::ad_1hot_t ad_fw;
  logic [1:0]        sz_in;
  logic              to_sext;

  //////////////////////////////////////////////////////////////////////
  // Encoding rules
  //////////////////////////////////////////////////////////////////////

  function automatic isa_pkg::as_1hot_t mode_src(input isa_pkg::word_t w);
    isa_pkg::as_1hot_t m;
    isa_pkg::reg_idx_t r;
    m = '0;
    // Single-operand register sits in the low nibble
    r = (w[15:13] == 3'b000) ? w[3:0] : w[11:8];
    if (w[15:13] == 3'b001) m[isa_pkg::DIR] = 1'b1;
    else if (r == isa_pkg::CG_REG) m[isa_pkg::CONST] = 1'b1;
    else if (r == isa_pkg::SR_REG && w[5]) m[isa_pkg::CONST] = 1'b1;
    else if (w[5:4] == 2'b00) m[isa_pkg::DIR] = 1'b1;
    else if (w[5:4] == 2'b10) m[isa_pkg::INDIR] = 1'b1;
    else if (r == isa_pkg::SR_REG) m[isa_pkg::ABS] = 1'b1;
    else if (r == isa_pkg::PC_REG) m[w[5] ? isa_pkg::IMM : isa_pkg::SYMB] = 1'b1;
    else m[w[5] ? isa_pkg::INDIR_I : isa_pkg::IDX] = 1'b1;
    return m;
  endfunction

  function automatic isa_pkg::ad_1hot_t mode_dst(input isa_pkg::word_t w);
    isa_pkg::ad_1hot_t m;
    m = '0;
    if (w[15:14] != 2'b00) begin
      if (!w[7]) m[isa_pkg::DIR] = 1'b1;
      else if (w[3:0] == isa_pkg::SR_REG) m[isa_pkg::ABS] = 1'b1;
      else if (w[3:0] == isa_pkg::PC_REG) m[isa_pkg::SYMB] = 1'b1;
      else m[isa_pkg::IDX] = 1'b1;
    end
    return m;
  endfunction

  function automatic logic [1:0] ext_words(input isa_pkg::word_t w);
    isa_pkg::as_1hot_t m;
    logic              s;
    logic              d;
    m = mode_src(w);
    s = m[isa_pkg::IDX] | m[isa_pkg::SYMB] | m[isa_pkg::ABS] | m[isa_pkg::IMM];
    // Only two-operand has an indexed destination
    d = (w[15:14] != 2'b00) & w[7];
    return {1'b0, s} + {1'b0, d};
  endfunction

  // Constant generator table for R2 and R3
  function automatic isa_pkg::word_t cgen(input isa_pkg::word_t w);
    isa_pkg::reg_idx_t r;
    r = (w[15:13] == 3'b000) ? w[3:0] : w[11:8];
    if (r == isa_pkg::CG_REG) begin
      case (w[5:4])
        2'b00:   return 16'h0000;
        2'b01:   return 16'h0001;
        2'b10:   return 16'h0002;
        default: return 16'hffff;
      endcase
    end
    return w[4] ? 16'h0008 : 16'h0004;
  endfunction

  // Whole decoded struct as the outputs should show it
  function automatic frontend_pkg::dec_inst_t decode_ref(input isa_pkg::word_t w);
    frontend_pkg::dec_inst_t d;
    logic                    so_t;
    logic                    jmp_t;
    logic                    to_t;
    so_t  = (w[15:13] == 3'b000);
    jmp_t = (w[15:13] == 3'b001);
    to_t  = !so_t && !jmp_t;
    d     = '0;
    d.typ = {to_t, jmp_t, so_t};
    if (so_t && w[9:7] != 3'd7) d.so[w[9:7]] = 1'b1;
    if (jmp_t) d.jmp[w[12:10]] = 1'b1;
    d.mov = (w[15:12] == 4'h4);
    d.bw  = w[6] && !jmp_t;
    d.as  = mode_src(w);
    d.ad  = mode_dst(w);
    d.sz  = ext_words(w);
    if (to_t) begin
      d.alu          = TO_ALU[w[15:12] - 4'd4];
      d.src[w[11:8]] = 1'b1;
    end else if (jmp_t) begin
      d.alu = 12'h008;
    end else begin
      d.alu = SO_ALU[w[9:7]];
      // RETI pops from the stack
      d.src[(w[9:7] == 3'd6) ? 4'd1 : w[3:0]] = 1'b1;
    end
    if (jmp_t) d.dest[0] = 1'b1;
    else if (so_t && (w[9:7] == 3'd4 || w[9:7] == 3'd5)) d.dest[1] = 1'b1;
    else d.dest[w[3:0]] = 1'b1;
    return d;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model of the word stream
  //////////////////////////////////////////////////////////////////////

  assign as_in   = mode_src(i_ir);
  assign sz_in   = ext_words(i_ir);
  assign as_fw   = mode_src(fw);
  assign ad_fw   = mode_dst(fw);
  // First extension word belongs to the source when it needs one
  assign to_sext = (pend == ext_words(fw)) &&
                   (as_fw[isa_pkg::IDX] | as_fw[isa_pkg::SYMB] |
                    as_fw[isa_pkg::ABS] | as_fw[isa_pkg::IMM]);

  always_ff @(posedge mclk_decode or posedge puc_rst) begin
    if (puc_rst) begin
      seen_first <= 1'b0;
      exp_vld    <= 1'b0;
      pend       <= 2'd0;
      fw         <= '0;
      exp_sext   <= '0;
      exp_dext   <= '0;
    end else begin
      exp_vld <= 1'b0;
      if (i_ir_vld && pend == 2'd0) begin
        seen_first <= 1'b1;
        fw         <= i_ir;
        pend       <= sz_in;
        exp_vld    <= (sz_in == 2'd0);
        if (as_in[isa_pkg::CONST]) exp_sext <= cgen(i_ir);
        else if (i_ir[15:13] == 3'b001)
          exp_sext <= isa_pkg::word_t'({{6{i_ir[9]}}, i_ir[9:0]}) * 2;
      end else if (i_ir_vld) begin
        pend    <= pend - 2'd1;
        exp_vld <= (pend == 2'd1);
        // Symbolic word is taken minus two
        if (to_sext) exp_sext <= i_ir - (as_fw[isa_pkg::SYMB] ? 16'd2 : 16'd0);
        else exp_dext <= i_ir - (ad_fw[isa_pkg::SYMB] ? 16'd2 : 16'd0);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  a_idle: assert property (@(posedge mclk_decode) disable iff (puc_rst)
    !seen_first |-> (!i_inst_vld && i_inst == '0 && i_sext == '0 && i_dext == '0))
    else begin
      fail_cnt++;
      $error("ERROR idle o_inst %h o_inst_vld %h o_sext %h o_dext %h", $sampled(i_inst),
             $sampled(i_inst_vld), $sampled(i_sext), $sampled(i_dext));
    end

  a_done: assert property (@(posedge mclk_decode) disable iff (puc_rst)
    i_inst_vld == exp_vld)
    else begin
      fail_cnt++;
      $error("ERROR o_inst_vld got %h expected %h", $sampled(i_inst_vld), $sampled(exp_vld));
    end

  // Fields follow the accepted first word from the next edge on and hold
  a_fields: assert property (@(posedge mclk_decode) disable iff (puc_rst)
    seen_first |-> i_inst == decode_ref(fw))
    else begin
      fail_cnt++;
      $error("ERROR o_inst got %h expected %h", $sampled(i_inst), decode_ref($sampled(fw)));
    end

  a_sext: assert property (@(posedge mclk_decode) disable iff (puc_rst)
    i_sext == exp_sext)
    else begin
      fail_cnt++;
      $error("ERROR o_sext got %h expected %h", $sampled(i_sext), $sampled(exp_sext));
    end

  a_dext: assert property (@(posedge mclk_decode) disable iff (puc_rst)
    i_dext == exp_dext)
    else begin
      fail_cnt++;
      $error("ERROR o_dext got %h expected %h", $sampled(i_dext), $sampled(exp_dext));
    end

endmodule

bind msp_frontend_top msp_frontend_chk u_chk (
  .mclk_decode (mclk_decode),
  .puc_rst     (puc_rst),
  .i_ir        (i_ir),
  .i_ir_vld    (i_ir_vld),
  .i_inst      (o_inst),
  .i_sext      (o_sext),
  .i_dext      (o_dext),
  .i_inst_vld  (o_inst_vld)
);

//--- logic/msp_frontend_top.sv
/* Fetch and decode frontend top level
   One word per valid strobe in, decoded fields and one done pulse per instruction out */
module msp_frontend_top (
  input  logic                    mclk_decode,
  input  logic                    puc_rst,
  input  isa_pkg::word_t          i_ir,
  input  logic                    i_ir_vld,
  output frontend_pkg::dec_inst_t o_inst,
  output isa_pkg::word_t          o_sext,
  output isa_pkg::word_t          o_dext,
  output logic                    o_inst_vld
);

  // Decode of the bus word
  frontend_pkg::dec_inst_t    dec;
  // Sequencer state and first-word strobe
  frontend_pkg::fetch_state_e state;
  logic                       first;

  opcode_decoder u_opcode_decoder (
    .i_ir  (i_ir),
    .o_dec (dec)
  );

  fetch_sequencer u_fetch_sequencer (
    .mclk_decode (mclk_decode),
    .puc_rst     (puc_rst),
    .i_ir_vld    (i_ir_vld),
    .i_dec       (dec),
    .o_state     (state),
    .o_first     (first),
    .o_inst      (o_inst),
    .o_inst_vld  (o_inst_vld)
  );

  ext_word_capture u_ext_word_capture (
    .mclk_decode (mclk_decode),
    .puc_rst     (puc_rst),
    .i_ir        (i_ir),
    .i_ir_vld    (i_ir_vld),
    .i_state     (state),
    .i_first     (first),
    .i_dec       (dec),
    .i_inst      (o_inst),
    .o_sext      (o_sext),
    .o_dext      (o_dext)
  );

endmodule

//--- logic/fetch_sequencer.sv
/* Fetch FSM stepping through DEC, EXT1 and EXT2 on valid words
   Holds the decoded first word and pulses done after the last word */
module fetch_sequencer (
  input  logic                       mclk_decode,
  input  logic                       puc_rst,
  input  logic                       i_ir_vld,
  input  frontend_pkg::dec_inst_t    i_dec,
  output frontend_pkg::fetch_state_e o_state,
  output logic                       o_first,
  output frontend_pkg::dec_inst_t    o_inst,
  output logic                       o_inst_vld
);

  frontend_pkg::fetch_state_e state_nxt;
  frontend_pkg::dec_inst_t    inst_nxt;
  logic                       last_word;

  // First word of an instruction
  assign o_first = i_ir_vld & (o_state == frontend_pkg::DEC);

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = o_state;
    last_word = 1'b0;
    case (o_state)
      frontend_pkg::DEC: begin
        if (o_first) begin
          if (i_dec.sz == isa_pkg::ext_cnt_t'(0)) begin
            last_word = 1'b1;
          end else begin
            state_nxt = frontend_pkg::EXT1;
          end
        end
      end
      frontend_pkg::EXT1: begin
        // Registered size picks the path
        if (i_ir_vld) begin
          if (o_inst.sz == isa_pkg::ext_cnt_t'(2)) begin
            state_nxt = frontend_pkg::EXT2;
          end else begin
            state_nxt = frontend_pkg::DEC;
            last_word = 1'b1;
          end
        end
      end
      frontend_pkg::EXT2: begin
        if (i_ir_vld) begin
          state_nxt = frontend_pkg::DEC;
          last_word = 1'b1;
        end
      end
      default: state_nxt = frontend_pkg::DEC;
    endcase
  end

  // Offset and constant leave through sext
  always_comb begin
    inst_nxt      = i_dec;
    inst_nxt.jofs = '0;
    inst_nxt.cnst = '0;
  end

  // State, decoded fields and done pulse
  always_ff @(posedge mclk_decode or posedge puc_rst) begin
    if (puc_rst) begin
      o_state    <= frontend_pkg::DEC;
      o_inst     <= '0;
      o_inst_vld <= 1'b0;
    end else begin
      o_state    <= state_nxt;
      o_inst_vld <= last_word;
      if (o_first) begin
        o_inst <= inst_nxt;
      end
    end
  end

endmodule

//--- logic/ext_word_capture.sv
/* Source and destination extension word registers
   Loaded with the constant or jump offset on the first word, then from EXT1 and EXT2 */
`include "frontend_macros.svh"

module ext_word_capture (
  input  logic                       mclk_decode,
  input  logic                       puc_rst,
  input  isa_pkg::word_t             i_ir,
  input  logic                       i_ir_vld,
  input  frontend_pkg::fetch_state_e i_state,
  input  logic                       i_first,
  input  frontend_pkg::dec_inst_t    i_dec,
  input  frontend_pkg::dec_inst_t    i_inst,
  output isa_pkg::word_t             o_sext,
  output isa_pkg::word_t             o_dext
);

  logic           is_sext;
  logic           sext_ld;
  logic           dext_ld;
  isa_pkg::word_t src_word;
  isa_pkg::word_t dst_word;

  // Source operand owns the first extension word
  assign is_sext = i_inst.as[isa_pkg::IDX] | i_inst.as[isa_pkg::SYMB] |
                   i_inst.as[isa_pkg::ABS] | i_inst.as[isa_pkg::IMM];

  assign sext_ld = i_ir_vld & (i_state == frontend_pkg::EXT1) & is_sext;
  assign dext_ld = i_ir_vld & (((i_state == frontend_pkg::EXT1) & ~is_sext) |
                               (i_state == frontend_pkg::EXT2));

  // Symbolic offset is relative to the word's own address
  assign src_word = i_ir + (i_inst.as[isa_pkg::SYMB] ? `SYMB_ADJ : '0);
  assign dst_word = i_ir + (i_inst.ad[isa_pkg::SYMB] ? `SYMB_ADJ : '0);

  // Source extension
  always_ff @(posedge mclk_decode or posedge puc_rst) begin
    if (puc_rst) begin
      o_sext <= '0;
    end else if (i_first) begin
      if (i_dec.as[isa_pkg::CONST]) begin
        o_sext <= i_dec.cnst;
      end else if (i_dec.typ[isa_pkg::INST_JMP]) begin
        o_sext <= i_dec.jofs;
      end
    end else if (sext_ld) begin
      o_sext <= src_word;
    end
  end

  // Destination extension
  always_ff @(posedge mclk_decode or posedge puc_rst) begin
    if (puc_rst) begin
      o_dext <= '0;
    end else if (dext_ld) begin
      o_dext <= dst_word;
    end
  end

endmodule

//--- logic/opcode_decoder.sv
/* Combinational decode of a first instruction word into the frontend struct
   Registered by the sequencer on the edge that accepts the word */
`include "frontend_macros.svh"

module opcode_decoder (
  input  isa_pkg::word_t          i_ir,
  output frontend_pkg::dec_inst_t o_dec
);

  isa_pkg::inst_type_t    typ;
  isa_pkg::so_1hot_t      so;
  logic [15:0]            to_1hot;
  logic [`ALU_CTL_W-1:0]  to_op;
  isa_pkg::as_1hot_t      as_m;
  isa_pkg::ad_1hot_t      ad_m;
  isa_pkg::word_t         cnst;
  isa_pkg::ext_cnt_t      sz;

  // One-hot over single-operand, jump, two-operand
  assign typ = {(i_ir[15:14] != 2'b00), (i_ir[15:13] == 3'b001), (i_ir[15:13] == 3'b000)};

  // Opcode 7 has no single-operand meaning and shifts out
  assign so = typ[isa_pkg::INST_SO] ? (isa_pkg::so_1hot_t'(1) << i_ir[9:7]) : '0;

  // Two-operand opcodes start at nibble 4
  assign to_1hot = typ[isa_pkg::INST_TO] ? (16'd1 << i_ir[15:12]) : 16'd0;
  assign to_op   = to_1hot[15:4];

  addr_mode_decoder u_amd (
    .i_ir       (i_ir),
    .i_so_type  (typ[isa_pkg::INST_SO]),
    .i_jmp_type (typ[isa_pkg::INST_JMP]),
    .i_to_type  (typ[isa_pkg::INST_TO]),
    .o_as       (as_m),
    .o_ad       (ad_m),
    .o_const    (cnst),
    .o_sz       (sz)
  );

  //////////////////////////////////////////////////////////////////////
  // Field assembly
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    o_dec      = '0;
    o_dec.typ  = typ;
    o_dec.so   = so;
    o_dec.jmp  = typ[isa_pkg::INST_JMP] ? (isa_pkg::jmp_1hot_t'(1) << i_ir[12:10]) : '0;
    o_dec.mov  = to_op[isa_pkg::MOV];
    o_dec.bw   = i_ir[6] & ~typ[isa_pkg::INST_JMP];
    o_dec.as   = as_m;
    o_dec.ad   = ad_m;
    o_dec.sz   = sz;
    o_dec.cnst = cnst;
    // Word offset to byte offset
    o_dec.jofs = {{(`WORD_W - 11){i_ir[9]}}, i_ir[9:0], 1'b0};

    // Source register
    if (typ[isa_pkg::INST_TO]) begin
      o_dec.src = isa_pkg::reg_1hot_t'(1) << i_ir[11:8];
    end else if (so[isa_pkg::RETI]) begin
      o_dec.src = isa_pkg::reg_1hot_t'(1) << isa_pkg::SP_REG;
    end else if (typ[isa_pkg::INST_SO]) begin
      o_dec.src = isa_pkg::reg_1hot_t'(1) << i_ir[3:0];
    end

    // Destination register
    if (typ[isa_pkg::INST_JMP]) begin
      o_dec.dest = isa_pkg::reg_1hot_t'(1) << isa_pkg::PC_REG;
    end else if (so[isa_pkg::PUSH] | so[isa_pkg::CALL]) begin
      // Stack pointer for the push
      o_dec.dest = isa_pkg::reg_1hot_t'(1) << isa_pkg::SP_REG;
    end else begin
      o_dec.dest = isa_pkg::reg_1hot_t'(1) << i_ir[3:0];
    end

    // ALU controls
    o_dec.alu[isa_pkg::ALU_SRC_INV] = to_op[isa_pkg::SUB] | to_op[isa_pkg::SUBC] |
                                      to_op[isa_pkg::CMP] | to_op[isa_pkg::BIC];
    o_dec.alu[isa_pkg::ALU_INC]     = to_op[isa_pkg::SUB] | to_op[isa_pkg::CMP];
    o_dec.alu[isa_pkg::ALU_INC_C]   = to_op[isa_pkg::ADDC] | to_op[isa_pkg::DADD] |
                                      to_op[isa_pkg::SUBC];
    // Jump target and RETI also go through the adder
    o_dec.alu[isa_pkg::ALU_ADD]     = to_op[isa_pkg::ADD] | to_op[isa_pkg::ADDC] |
                                      to_op[isa_pkg::SUB] | to_op[isa_pkg::SUBC] |
                                      to_op[isa_pkg::CMP] | typ[isa_pkg::INST_JMP] |
                                      so[isa_pkg::RETI];
    o_dec.alu[isa_pkg::ALU_AND]     = to_op[isa_pkg::ANDX] | to_op[isa_pkg::BIC] |
                                      to_op[isa_pkg::BITC];
    o_dec.alu[isa_pkg::ALU_OR]      = to_op[isa_pkg::BIS];
    o_dec.alu[isa_pkg::ALU_XOR]     = to_op[isa_pkg::XORX];
    o_dec.alu[isa_pkg::ALU_DADD]    = to_op[isa_pkg::DADD];
    o_dec.alu[isa_pkg::ALU_STAT_7]  = to_op[isa_pkg::BITC] | to_op[isa_pkg::ANDX] |
                                      so[isa_pkg::SXT];
    o_dec.alu[isa_pkg::ALU_STAT_F]  = to_op[isa_pkg::ADD] | to_op[isa_pkg::ADDC] |
                                      to_op[isa_pkg::SUB] | to_op[isa_pkg::SUBC] |
                                      to_op[isa_pkg::CMP] | to_op[isa_pkg::DADD] |
                                      to_op[isa_pkg::BITC] | to_op[isa_pkg::XORX] |
                                      to_op[isa_pkg::ANDX] | so[isa_pkg::RRC] |
                                      so[isa_pkg::RRA] | so[isa_pkg::SXT];
    o_dec.alu[isa_pkg::ALU_SHIFT]   = so[isa_pkg::RRC] | so[isa_pkg::RRA];
    // Compare and bit test keep the destination
    o_dec.alu[isa_pkg::EXEC_NO_WR]  = to_op[isa_pkg::CMP] | to_op[isa_pkg::BITC];
  end

endmodule

//--- logic/addr_mode_decoder.sv
/* Source and destination addressing-mode decode of a first word
   Also gives the constant generator value and the extension word count */
module addr_mode_decoder (
  input  isa_pkg::word_t    i_ir,
  input  logic              i_so_type,
  input  logic              i_jmp_type,
  input  logic              i_to_type,
  output isa_pkg::as_1hot_t o_as,
  output isa_pkg::ad_1hot_t o_ad,
  output isa_pkg::word_t    o_const,
  output isa_pkg::ext_cnt_t o_sz
);

  isa_pkg::reg_idx_t src_reg;
  isa_pkg::reg_idx_t dst_reg;
  logic              src_ext;
  logic              dst_ext;

  // Single-operand keeps its register in the low nibble
  assign src_reg = i_so_type ? i_ir[3:0] : i_ir[11:8];
  assign dst_reg = i_ir[3:0];

  //////////////////////////////////////////////////////////////////////
  // Source mode and constant generator
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    o_as    = '0;
    o_const = '0;
    if (i_jmp_type) begin
      o_as[isa_pkg::DIR] = 1'b1;
    end else if (src_reg == isa_pkg::CG_REG) begin
      // R3 always a constant
      o_as[isa_pkg::CONST] = 1'b1;
      case (i_ir[5:4])
        2'b11:   o_const = 16'hffff;
        2'b10:   o_const = 16'h0002;
        2'b01:   o_const = 16'h0001;
        default: o_const = 16'h0000;
      endcase
    end else if (src_reg == isa_pkg::SR_REG) begin
      // R2 gives absolute, 4 or 8
      case (i_ir[5:4])
        2'b11: begin
          o_as[isa_pkg::CONST] = 1'b1;
          o_const              = 16'h0008;
        end
        2'b10: begin
          o_as[isa_pkg::CONST] = 1'b1;
          o_const              = 16'h0004;
        end
        2'b01:   o_as[isa_pkg::ABS] = 1'b1;
        default: o_as[isa_pkg::DIR] = 1'b1;
      endcase
    end else if (src_reg == isa_pkg::PC_REG) begin
      case (i_ir[5:4])
        2'b11:   o_as[isa_pkg::IMM]   = 1'b1;
        2'b10:   o_as[isa_pkg::INDIR] = 1'b1;
        2'b01:   o_as[isa_pkg::SYMB]  = 1'b1;
        default: o_as[isa_pkg::DIR]   = 1'b1;
      endcase
    end else begin
      case (i_ir[5:4])
        2'b11:   o_as[isa_pkg::INDIR_I] = 1'b1;
        2'b10:   o_as[isa_pkg::INDIR]   = 1'b1;
        2'b01:   o_as[isa_pkg::IDX]     = 1'b1;
        default: o_as[isa_pkg::DIR]     = 1'b1;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Destination mode, two-operand only
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    o_ad = '0;
    if (i_to_type) begin
      if (!i_ir[7]) begin
        o_ad[isa_pkg::DIR] = 1'b1;
      end else if (dst_reg == isa_pkg::SR_REG) begin
        o_ad[isa_pkg::ABS] = 1'b1;
      end else if (dst_reg == isa_pkg::PC_REG) begin
        o_ad[isa_pkg::SYMB] = 1'b1;
      end else begin
        o_ad[isa_pkg::IDX] = 1'b1;
      end
    end
  end

  // One word per operand that needs an address or immediate
  assign src_ext = o_as[isa_pkg::IDX] | o_as[isa_pkg::SYMB] |
                   o_as[isa_pkg::ABS] | o_as[isa_pkg::IMM];
  assign dst_ext = (o_ad[isa_pkg::IDX] | o_ad[isa_pkg::SYMB] | o_ad[isa_pkg::ABS]) &
                   ~i_so_type;
  assign o_sz    = {1'b0, src_ext} + {1'b0, dst_ext};

endmodule

//--- logic/frontend_pkg.sv
/* Microarchitecture types of the frontend
   Fetch FSM states and the decoded-instruction struct passed between blocks */
package frontend_pkg;

  // Position within one instruction
  typedef enum logic [1:0] {
    DEC  = 2'd0,
    EXT1 = 2'd1,
    EXT2 = 2'd2
  } fetch_state_e;

  // Decoded first word
  typedef struct packed {
    // Instruction class and opcode one-hots
    isa_pkg::inst_type_t typ;
    isa_pkg::so_1hot_t   so;
    isa_pkg::jmp_1hot_t  jmp;
    isa_pkg::alu_ctl_t   alu;
    logic                mov;
    // Byte access
    logic                bw;
    // Register selects
    isa_pkg::reg_1hot_t  src;
    isa_pkg::reg_1hot_t  dest;
    // Operand modes
    isa_pkg::as_1hot_t   as;
    isa_pkg::ad_1hot_t   ad;
    // Extension words still to come
    isa_pkg::ext_cnt_t   sz;
    // Only meaningful at decode time
    isa_pkg::word_t      jofs;
    isa_pkg::word_t      cnst;
  } dec_inst_t;

endpackage

//--- logic/isa_pkg.sv
/* Types for the MSP430 instruction encoding
   One-hot field vectors with their bit positions named below */
`include "frontend_macros.svh"

package isa_pkg;

  // Words and registers
  typedef logic [`WORD_W-1:0]    word_t;
  typedef logic [3:0]            reg_idx_t;
  typedef logic [`REG_NR-1:0]    reg_1hot_t;

  // One-hot decoded fields
  typedef logic [2:0]            inst_type_t;
  typedef logic [`SO_NR-1:0]     so_1hot_t;
  typedef logic [`JMP_NR-1:0]    jmp_1hot_t;
  typedef logic [`ALU_CTL_W-1:0] alu_ctl_t;
  typedef logic [`AS_W-1:0]      as_1hot_t;
  typedef logic [`AD_W-1:0]      ad_1hot_t;

  // Extension words after the first, 0 to 2
  typedef logic [1:0]            ext_cnt_t;

  // Special registers
  localparam reg_idx_t PC_REG = 4'd0;
  localparam reg_idx_t SP_REG = 4'd1;
  localparam reg_idx_t SR_REG = 4'd2;
  localparam reg_idx_t CG_REG = 4'd3;

  // Instruction type
  localparam int INST_SO  = 0;
  localparam int INST_JMP = 1;
  localparam int INST_TO  = 2;

  // Single-operand opcodes
  localparam int RRC  = 0;
  localparam int SWPB = 1;
  localparam int RRA  = 2;
  localparam int SXT  = 3;
  localparam int PUSH = 4;
  localparam int CALL = 5;
  localparam int RETI = 6;

  // Addressing modes, shared by source and destination
  localparam int DIR     = 0;
  localparam int IDX     = 1;
  localparam int INDIR   = 2;
  localparam int INDIR_I = 3;
  localparam int SYMB    = 4;
  localparam int IMM     = 5;
  localparam int ABS     = 6;
  localparam int CONST   = 7;

  // Two-operand opcodes, upper opcode nibble minus 4
  localparam int MOV  = 0;
  localparam int ADD  = 1;
  localparam int ADDC = 2;
  localparam int SUBC = 3;
  localparam int SUB  = 4;
  localparam int CMP  = 5;
  localparam int DADD = 6;
  localparam int BITC = 7;
  localparam int BIC  = 8;
  localparam int BIS  = 9;
  localparam int XORX = 10;
  localparam int ANDX = 11;

  // ALU controls
  localparam int ALU_SRC_INV = 0;
  localparam int ALU_INC     = 1;
  localparam int ALU_INC_C   = 2;
  localparam int ALU_ADD     = 3;
  localparam int ALU_AND     = 4;
  localparam int ALU_OR      = 5;
  localparam int ALU_XOR     = 6;
  localparam int ALU_DADD    = 7;
  localparam int ALU_STAT_7  = 8;
  localparam int ALU_STAT_F  = 9;
  localparam int ALU_SHIFT   = 10;
  localparam int EXEC_NO_WR  = 11;

endpackage

//--- logic/frontend_macros.svh
/* Widths and counts shared by the fetch and decode frontend
   Included by the ISA package and by RTL that needs the raw constants */
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// Bus and instruction word
`define WORD_W 16

// Register file size
`define REG_NR 16

// Single-operand opcodes without an IRQ slot
`define SO_NR 7

// Jump conditions
`define JMP_NR 8

// ALU control vector
`define ALU_CTL_W 12

// One-hot addressing modes with bit 7 as the constant flag
`define AS_W 8
`define AD_W 8

// Minus two in two's complement
`define SYMB_ADJ 16'hfffe

`endif
